//--- logic/servo_bus_slave.sv
// servo bus slave: four-phase req/ack handshake, window decode and register strobes
`timescale 1ns/1ps

module servo_bus_slave
    import servo_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        req,
    input  bus_req_t    cmd,
    output logic        ack,
    output logic [31:0] rdata,
    output reg_wr_t     reg_wr,
    output logic [3:0]  rd_offset,
    input  logic [31:0] rd_word
);

    // handshake phases
    typedef enum logic [1:0] {
        st_idle,
        st_strobe,
        st_ack,
        st_release
    } state_t;

    state_t      state;
    logic        in_window;
    logic        take_req;
    logic        wr_strobe;
    logic [3:0]  wr_offset;
    logic [31:0] wr_data;

    //////////////////////////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////////////////////////

    // window is servo_base .. servo_base + servo_window - 1
    assign in_window = (cmd.addr >= bus_addr_t'(servo_base)) &&
                       (cmd.addr <  bus_addr_t'(servo_base + servo_window));

    // word offset inside the window, also drives the read mux
    assign rd_offset = 4'(cmd.addr - bus_addr_t'(servo_base));

    // new transfer accepted only from idle
    assign take_req = (state == st_idle) && req && in_window;

    //////////////////////////////////////////////////////////////////////
    // handshake fsm
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state     <= st_idle;
            ack       <= 1'b0;
            rdata     <= '0;
            wr_strobe <= 1'b0;
        end else begin
            // strobe is a single cycle pulse
            wr_strobe <= 1'b0;
            case (state)
                st_idle: begin
                    // out of window requests are left alone
                    if (take_req) begin
                        state     <= st_strobe;
                        wr_strobe <= cmd.wr;
                        rdata     <= rd_word;
                    end
                end
                st_strobe: begin
                    // write has landed, rdata already valid
                    state <= st_ack;
                    ack   <= 1'b1;
                end
                st_ack: begin
                    // host may hold req as long as it likes
                    if (!req) begin
                        state <= st_release;
                    end
                end
                default: begin
                    state <= st_idle;
                    ack   <= 1'b0;
                end
            endcase
        end
    end

    // write payload, captured with the request
    always_ff @(posedge clk) begin
        if (take_req) begin
            wr_offset <= rd_offset;
            wr_data   <= cmd.wdata;
        end
    end

    assign reg_wr = '{strobe: wr_strobe, offset: wr_offset, data: wr_data};

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // ack only answers a request held for the whole setup
    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!reset)
        $rose(ack) |-> req && $past(req) && $past(req, 2)
    );

    // one write per req high period
    a_one_strobe: assert property (
        @(posedge clk) disable iff (!reset)
        wr_strobe |=> (!wr_strobe until !req)
    );

endmodule

//--- logic/servo_pkg.sv
// servo pulse subsystem shared definitions: register map, channel count and bus structs
package servo_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes and address window
    //////////////////////////////////////////////////////////////////////

    // number of pulse outputs
    localparam int servo_channels = 8;

    // first bus address claimed by the subsystem
    localparam int servo_base = 16;

    // register offsets inside the window
    localparam int reg_period       = 0;
    localparam int reg_config       = 1;
    localparam int reg_status       = 2;
    localparam int reg_on_time_base = 3;

    // period, config, status plus one on-time per channel
    localparam int servo_window = reg_on_time_base + servo_channels;

    // config bit 31 gates all channels, bits 0..7 enable single channels
    localparam int cfg_global_enable = 31;

    //////////////////////////////////////////////////////////////////////
    // bus side
    //////////////////////////////////////////////////////////////////////

    typedef logic [7:0] bus_addr_t;

    // host command, held stable while req is high
    typedef struct packed {
        logic        wr;
        bus_addr_t   addr;
        logic [31:0] wdata;
    } bus_req_t;

    // single cycle write strobe from slave to register file
    typedef struct packed {
        logic        strobe;
        logic [3:0]  offset;
        logic [31:0] data;
    } reg_wr_t;

    //////////////////////////////////////////////////////////////////////
    // register file to pulse bank
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [31:0]               period;
        logic                      global_enable;
        logic [servo_channels-1:0] channel_enable;
    } timing_t;

    // one on-time word per channel, in clock cycles
    typedef logic [servo_channels-1:0][31:0] on_time_array_t;

    // read-only status word
    typedef struct packed {
        logic [15:0]               frame_count;
        logic [7:0]                reserved;
        logic [servo_channels-1:0] too_long;
    } status_t;

endpackage

//--- logic/servo_pulse_bank.sv
// servo pulse bank: frame counter and one on-time counter per output
`timescale 1ns/1ps

module servo_pulse_bank
    import servo_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  timing_t                   timing,
    input  on_time_array_t            on_times,
    output logic                      frame_tick,
    output logic [servo_channels-1:0] servo
);

    logic [31:0] frame_cnt;

    //////////////////////////////////////////////////////////////////////
    // frame counter
    //////////////////////////////////////////////////////////////////////

    // loads period at zero, so a frame lasts period + 1 cycles
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            frame_cnt <= '0;
        end else if (!timing.global_enable) begin
            // parked at zero, first tick follows the enable at once
            frame_cnt <= '0;
        end else if (frame_cnt == '0) begin
            frame_cnt <= timing.period;
        end else begin
            frame_cnt <= frame_cnt - 32'd1;
        end
    end

    // start of frame
    assign frame_tick = timing.global_enable && (frame_cnt == '0);

    //////////////////////////////////////////////////////////////////////
    // channel counters
    //////////////////////////////////////////////////////////////////////

    for (genvar ch = 0; ch < servo_channels; ch++) begin : g_chan

        logic [31:0] on_cnt;
        logic        chan_on;

        // both enables needed for this output
        assign chan_on = timing.global_enable && timing.channel_enable[ch];

        always_ff @(posedge clk or negedge reset) begin
            if (!reset) begin
                on_cnt    <= '0;
                servo[ch] <= 1'b0;
            end else if (!chan_on) begin
                on_cnt    <= '0;
                servo[ch] <= 1'b0;
            end else if (frame_tick) begin
                // zero on-time keeps the output low
                on_cnt    <= on_times[ch];
                servo[ch] <= on_times[ch] != '0;
            end else if (servo[ch]) begin
                // on_cnt holds the cycles left including this one
                on_cnt    <= on_cnt - 32'd1;
                servo[ch] <= on_cnt > 32'd1;
            end
        end

        // output drops one cycle after either enable falls
        a_off_when_disabled: assert property (
            @(posedge clk) disable iff (!reset)
            $fell(chan_on) |=> !servo[ch]
        );

    end

endmodule

//--- logic/servo_reg_file.sv
// servo register file: period, config, on-times, status word and read mux
`timescale 1ns/1ps

module servo_reg_file
    import servo_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  reg_wr_t        reg_wr,
    input  logic [3:0]     rd_offset,
    output logic [31:0]    rd_word,
    input  logic           frame_tick,
    output timing_t        timing,
    output on_time_array_t on_times
);

    logic [31:0]               period;
    logic [31:0]               cfg_word;
    logic [15:0]               frame_count;
    logic [servo_channels-1:0] too_long;
    status_t                   status;
    logic                      wr_is_on_time;
    logic [3:0]                wr_index;
    logic                      rd_is_on_time;
    logic [3:0]                rd_index;

    // on-time slot decode for write and read side
    assign wr_is_on_time = (reg_wr.offset >= 4'(reg_on_time_base)) &&
                           (reg_wr.offset <  4'(reg_on_time_base + servo_channels));
    assign wr_index      = reg_wr.offset - 4'(reg_on_time_base);
    assign rd_is_on_time = (rd_offset >= 4'(reg_on_time_base)) &&
                           (rd_offset <  4'(reg_on_time_base + servo_channels));
    assign rd_index      = rd_offset - 4'(reg_on_time_base);

    //////////////////////////////////////////////////////////////////////
    // register writes
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            period   <= '0;
            cfg_word <= '0;
            on_times <= '0;
        end else if (reg_wr.strobe) begin
            if (reg_wr.offset == 4'(reg_period)) begin
                period                      <= reg_wr.data;
                // timing changed, stop the outputs until re-enabled
                cfg_word[cfg_global_enable] <= 1'b0;
            end else if (reg_wr.offset == 4'(reg_config)) begin
                cfg_word <= reg_wr.data;
            end else if (wr_is_on_time) begin
                on_times[wr_index]          <= reg_wr.data;
                cfg_word[cfg_global_enable] <= 1'b0;
            end
            // status writes fall through and change nothing
        end
    end

    // frames since reset, wraps at 16 bits
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            frame_count <= '0;
        end else if (frame_tick) begin
            frame_count <= frame_count + 16'd1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // status and read mux
    //////////////////////////////////////////////////////////////////////

    // pulse would still be high when the next frame starts
    always_comb begin
        for (int i = 0; i < servo_channels; i++) begin
            too_long[i] = on_times[i] > period;
        end
    end

    assign status = '{frame_count: frame_count, reserved: 8'h00, too_long: too_long};

    always_comb begin
        rd_word = '0;
        if (rd_offset == 4'(reg_period)) begin
            rd_word = period;
        end else if (rd_offset == 4'(reg_config)) begin
            rd_word = cfg_word;
        end else if (rd_offset == 4'(reg_status)) begin
            rd_word = status;
        end else if (rd_is_on_time) begin
            rd_word = on_times[rd_index];
        end
    end

    assign timing = '{period:         period,
                      global_enable:  cfg_word[cfg_global_enable],
                      channel_enable: cfg_word[servo_channels-1:0]};

    // the period never moves under a running frame counter
    a_period_stable: assert property (
        @(posedge clk) disable iff (!reset)
        $changed(period) |-> !cfg_word[cfg_global_enable]
    );

endmodule

//--- logic/servo_top.sv
// servo subsystem top: bus slave, register file and pulse bank
`timescale 1ns/1ps

module servo_top
    import servo_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      req,
    input  bus_req_t                  cmd,
    output logic                      ack,
    output logic [31:0]               rdata,
    output logic [servo_channels-1:0] servo
);

    reg_wr_t        reg_wr;
    logic [3:0]     rd_offset;
    logic [31:0]    rd_word;
    timing_t        timing;
    on_time_array_t on_times;
    logic           frame_tick;

    // host side handshake
    servo_bus_slave u_servo_bus_slave (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .cmd       (cmd),
        .ack       (ack),
        .rdata     (rdata),
        .reg_wr    (reg_wr),
        .rd_offset (rd_offset),
        .rd_word   (rd_word)
    );

    // register storage and status
    servo_reg_file u_servo_reg_file (
        .clk        (clk),
        .reset      (reset),
        .reg_wr     (reg_wr),
        .rd_offset  (rd_offset),
        .rd_word    (rd_word),
        .frame_tick (frame_tick),
        .timing     (timing),
        .on_times   (on_times)
    );

    // pulse outputs
    servo_pulse_bank u_servo_pulse_bank (
        .clk        (clk),
        .reset      (reset),
        .timing     (timing),
        .on_times   (on_times),
        .frame_tick (frame_tick),
        .servo      (servo)
    );

endmodule

//--- verif/servo_bus_tasks.svh
// servo bus host tasks: register addresses, write, read and out-of-window probe
`ifndef servo_bus_tasks_svh
`define servo_bus_tasks_svh

// bus address of a register offset
function automatic bus_addr_t reg_addr(input int offset);
    return bus_addr_t'(servo_base + offset);
endfunction

// bus address of a channel on-time
function automatic bus_addr_t on_time_addr(input int channel);
    return reg_addr(reg_on_time_base + channel);
endfunction

// one full four-phase transfer, req held for hold extra cycles after ack
task automatic bus_xfer(input logic wr, input bus_addr_t addr, input logic [31:0] wdata,
                        input int hold, output logic [31:0] data);
    @(posedge clk);
    cmd <= '{wr: wr, addr: addr, wdata: wdata};
    req <= 1'b1;
    // wait for the slave to answer
    do @(posedge clk); while (!ack);
    data = rdata;
    repeat (hold) @(posedge clk);
    req <= 1'b0;
    // ack must be low before the next request
    do @(posedge clk); while (ack);
endtask

task automatic bus_write(input bus_addr_t addr, input logic [31:0] wdata, input int hold);
    logic [31:0] unused;
    bus_xfer(1'b1, addr, wdata, hold, unused);
endtask

task automatic bus_read(input bus_addr_t addr, input int hold, output logic [31:0] data);
    bus_xfer(1'b0, addr, 32'h0, hold, data);
endtask

// raise req on a foreign address and report whether ack came within cycles
task automatic bus_probe(input bus_addr_t addr, input int cycles, output logic acked);
    acked = 1'b0;
    @(posedge clk);
    cmd <= '{wr: 1'b0, addr: addr, wdata: 32'h0};
    req <= 1'b1;
    repeat (cycles) begin
        @(posedge clk);
        acked = acked | ack;
    end
    req <= 1'b0;
    @(posedge clk);
endtask

`endif

//--- verif/servo_tb.sv
// servo subsystem testbench checking handshake, readback, enable clear, pulse width and status
`timescale 1ns/1ps

module servo_tb
    import servo_pkg::*;
();

    // pulse test period range and number of frames watched
    localparam int min_period      = 40;
    localparam int max_period      = 80;
    localparam int frames_run      = 4;
    localparam int watchdog_cycles = (max_period + 1) * frames_run * 4 + 2000;

    logic                      clk;
    logic                      reset;
    logic                      req;
    bus_req_t                  cmd;
    logic                      ack;
    logic [31:0]               rdata;
    logic [servo_channels-1:0] servo;

    int pass_count = 0;
    int fail_count = 0;
    int test_fails = 0;

    // model of what the registers should hold
    logic [31:0]               exp_period;
    logic [31:0]               exp_on [servo_channels];
    logic [servo_channels-1:0] exp_active = '0;
    logic                      monitor_on = 1'b0;
    logic                      cmd_in_window;

    // pulse monitor state
    int                        cycle      = 0;
    int                        rise_count = 0;
    int                        high_len   [servo_channels] = '{default: 0};
    int                        last_rise  [servo_channels] = '{default: 0};
    logic [servo_channels-1:0] seen_rise  = '0;
    logic [servo_channels-1:0] servo_q    = '0;

    servo_top u_servo_top (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .cmd   (cmd),
        .ack   (ack),
        .rdata (rdata),
        .servo (servo)
    );

    `include "servo_bus_tasks.svh"

    task automatic tally_pass();
        pass_count++;
    endtask

    task automatic record_failure(input string msg);
        fail_count++;
        $display("[ERROR] %0t ns: %s", $time, msg);
    endtask

    // one summary line per finished test
    task automatic close_test(input string name);
        $display("test %s done, %0d errors", name, fail_count - test_fails);
        test_fails = fail_count;
    endtask

    task automatic read_expect(input bus_addr_t addr, input logic [31:0] expected,
                               input string what);
        logic [31:0] data;
        bus_read(addr, $urandom % 6, data);
        assert (data === expected) tally_pass();
        else record_failure($sformatf("%s read %h, expected %h", what, data, expected));
    endtask

    // a pulse longer than the period overruns into the next frame
    function automatic logic [servo_channels-1:0] too_long_model();
        logic [servo_channels-1:0] bits;
        for (int ch = 0; ch < servo_channels; ch++) begin
            bits[ch] = exp_on[ch] > exp_period;
        end
        return bits;
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("Checks failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // handshake checks
    //////////////////////////////////////////////////////////////////////

    assign cmd_in_window = (cmd.addr >= bus_addr_t'(servo_base)) &&
                           (cmd.addr <  bus_addr_t'(servo_base + servo_window));

    // ack two edges after req is first seen
    ack_latency: assert property (@(posedge clk) disable iff (!reset)
        $rose(req) && cmd_in_window |-> !ack ##1 !ack ##1 ack)
        else record_failure("ack did not rise two edges after req");

    // back-pressure keeps ack up
    ack_hold: assert property (@(posedge clk) disable iff (!reset)
        ack && req |=> ack)
        else record_failure("ack dropped while req was still high");

    // slave sees req low and drops ack on the following edge
    ack_release: assert property (@(posedge clk) disable iff (!reset)
        $fell(req) && ack |-> ##1 ack ##1 !ack)
        else record_failure("ack did not fall one edge after req was seen low");

    foreign_ignored: assert property (@(posedge clk) disable iff (!reset)
        req && !cmd_in_window |-> !ack)
        else record_failure("out of window address was acknowledged");

    //////////////////////////////////////////////////////////////////////
    // pulse monitor
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycle   <= cycle + 1;
        servo_q <= servo;
        for (int ch = 0; ch < servo_channels; ch++) begin
            if (servo[ch] && !servo_q[ch]) begin
                // frame spacing measured rise to rise
                if (monitor_on && seen_rise[ch]) begin
                    assert (cycle - last_rise[ch] == exp_period + 1) tally_pass();
                    else record_failure($sformatf("channel %0d frame of %0d cycles",
                                                  ch, cycle - last_rise[ch]));
                end
                high_len[ch]  <= 1;
                last_rise[ch] <= cycle;
                seen_rise[ch] <= monitor_on;
                if (ch == 0) begin
                    rise_count <= rise_count + 1;
                end
            end else if (servo[ch]) begin
                high_len[ch] <= high_len[ch] + 1;
            end else if (servo_q[ch] && monitor_on && seen_rise[ch]) begin
                assert (high_len[ch] == exp_on[ch]) tally_pass();
                else record_failure($sformatf("channel %0d high for %0d cycles, expected %0d",
                                              ch, high_len[ch], exp_on[ch]));
            end
            // disabled or zero on-time channels stay quiet
            if (monitor_on && !exp_active[ch]) begin
                assert (!servo[ch])
                else record_failure($sformatf("channel %0d high while inactive", ch));
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] cfg;
        logic [31:0] data;
        logic        acked;
        status_t     st_a;
        status_t     st_b;
        status_t     st_exp;
        int          rises_a;
        int          ch_pick;

        void'($urandom(32'h40aa4864));
        reset = 1'b0;
        req   = 1'b0;
        cmd   = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b1;
        @(posedge clk);

        // handshake with random req hold lengths inside the tasks
        exp_period = $urandom;
        bus_write(reg_addr(reg_period), exp_period, $urandom % 6);
        read_expect(reg_addr(reg_period), exp_period, "period");
        bus_probe(8'h05, 4, acked);
        assert (!acked) tally_pass();
        else record_failure("address below the window was acknowledged");
        bus_probe(on_time_addr(servo_channels), 4, acked);
        assert (!acked) tally_pass();
        else record_failure("address above the window was acknowledged");
        close_test("handshake");

        // readback with the global enable off
        cfg = $urandom & 32'h7fff_ffff;
        bus_write(reg_addr(reg_config), cfg, $urandom % 6);
        for (int ch = 0; ch < servo_channels; ch++) begin
            exp_on[ch] = $urandom;
            bus_write(on_time_addr(ch), exp_on[ch], $urandom % 6);
        end
        read_expect(reg_addr(reg_config), cfg, "config");
        for (int ch = 0; ch < servo_channels; ch++) begin
            read_expect(on_time_addr(ch), exp_on[ch], $sformatf("on-time %0d", ch));
        end
        bus_read(reg_addr(reg_status), $urandom % 6, data);
        st_a = data;
        assert (st_a.too_long === too_long_model()) tally_pass();
        else record_failure($sformatf("too_long %b after readback", st_a.too_long));
        bus_write(reg_addr(reg_status), ~data, $urandom % 6);
        // no frame has run since reset so the count is still zero
        st_exp = '{frame_count: 16'h0000, reserved: 8'h00, too_long: too_long_model()};
        read_expect(reg_addr(reg_status), st_exp, "status after write");
        close_test("readback");

        // period and on-time writes both drop bit 31
        // channel 0 enabled so a missed clear shows on the outputs
        cfg = 32'h8000_0001 | ($urandom & 32'hfe);
        bus_write(reg_addr(reg_config), cfg, $urandom % 6);
        read_expect(reg_addr(reg_config), cfg, "config enabled");
        bus_write(reg_addr(reg_period), exp_period, $urandom % 6);
        read_expect(reg_addr(reg_config), cfg & 32'h7fff_ffff, "config after period");
        assert (servo === '0) tally_pass();
        else record_failure("outputs high after period write");
        bus_write(reg_addr(reg_config), cfg, $urandom % 6);
        ch_pick = $urandom % servo_channels;
        bus_write(on_time_addr(ch_pick), exp_on[ch_pick], $urandom % 6);
        read_expect(reg_addr(reg_config), cfg & 32'h7fff_ffff, "config after on-time");
        assert (servo === '0) tally_pass();
        else record_failure("outputs high after on-time write");
        close_test("enable clear");

        // pulse widths with channel 0 always active as frame reference
        exp_period = min_period + $urandom % (max_period - min_period + 1);
        bus_write(reg_addr(reg_period), exp_period, $urandom % 6);
        // channel 1 enabled with a zero on-time and channel 7 left disabled
        cfg = 32'h8000_0003 | ($urandom & 32'h7c);
        for (int ch = 0; ch < servo_channels; ch++) begin
            exp_on[ch] = $urandom % (exp_period + 1);
            if (ch == 0 && exp_on[ch] == 0) begin
                exp_on[ch] = 1;
            end
            if (ch == 1) begin
                exp_on[ch] = 0;
            end
            exp_active[ch] = cfg[ch] && exp_on[ch] != 0;
            bus_write(on_time_addr(ch), exp_on[ch], $urandom % 6);
        end
        bus_read(reg_addr(reg_status), $urandom % 6, data);
        st_a    = data;
        rises_a = rise_count;
        monitor_on <= 1'b1;
        bus_write(reg_addr(reg_config), cfg, $urandom % 6);
        while (rise_count - rises_a < frames_run) begin
            @(posedge clk);
        end
        monitor_on <= 1'b0;
        @(posedge clk);
        bus_write(reg_addr(reg_config), cfg & 32'h7fff_ffff, $urandom % 6);
        close_test("pulse width");

        // frame count against frame starts seen on channel 0
        bus_read(reg_addr(reg_status), $urandom % 6, data);
        st_b = data;
        assert (st_b.frame_count - st_a.frame_count == 16'(rise_count - rises_a)) tally_pass();
        else record_failure($sformatf("frame_count moved by %0d, saw %0d frame starts",
                                      16'(st_b.frame_count - st_a.frame_count),
                                      rise_count - rises_a));
        assert (st_a.too_long === '0) tally_pass();
        else record_failure($sformatf("too_long %b with short on-times", st_a.too_long));
        // stretch a random set of channels past the period
        for (int ch = 0; ch < servo_channels; ch++) begin
            if ($urandom % 2 == 1) begin
                exp_on[ch] = exp_period + 1 + $urandom % 50;
                bus_write(on_time_addr(ch), exp_on[ch], $urandom % 6);
            end
        end
        bus_read(reg_addr(reg_status), $urandom % 6, data);
        st_b = data;
        assert (st_b.too_long === too_long_model()) tally_pass();
        else record_failure($sformatf("too_long %b, expected %b", st_b.too_long,
                                      too_long_model()));
        close_test("status");

        $display("checks: %0d passed, %0d errors", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+verif
logic/servo_pkg.sv
logic/servo_bus_slave.sv
logic/servo_reg_file.sv
logic/servo_pulse_bank.sv
logic/servo_top.sv
verif/servo_tb.sv
